/* tb/spi_stim.txt */
# cpol cpha divider select count word0 word1 word2 word3 status, all hex
# A word of 00 is replaced by a pseudo-random byte, status is read after the RX words
0 0 0 0 1 a5 00 00 00 05
0 1 0 1 2 3c c3 00 00 05
1 0 0 2 3 ff 01 80 00 05
1 1 0 3 4 00 00 00 00 05
0 0 1 1 4 12 34 56 78 05
0 1 1 2 2 81 7e 00 00 05
1 0 2 3 1 55 00 00 00 05
1 1 2 0 3 aa 00 0f 00 05
0 0 3 2 2 00 f0 00 00 05
0 1 3 3 3 69 96 00 00 05
1 0 4 0 4 de ad be ef 05
1 1 4 1 2 c8 00 00 00 05
0 0 2 3 1 00 00 00 00 05
1 1 1 2 4 01 02 04 08 05
0 1 4 0 1 7f 00 00 00 05
1 0 3 1 2 00 00 00 00 05

/* list.f */
source/spi_pkg.sv
source/spi_stream_if.sv
source/spi_word_fifo.sv
source/spi_reg_decode.sv
source/spi_shift_engine.sv
source/spi_ctrl_top.sv
tb/tb_spi_ctrl.sv

/* Bender.yml */
package:
  name: spi_ctrl

sources:
  - target: any(rtl, test)
    files:
      - source/spi_pkg.sv
      - source/spi_stream_if.sv
      - source/spi_word_fifo.sv
      - source/spi_reg_decode.sv
      - source/spi_shift_engine.sv
      - source/spi_ctrl_top.sv
  - target: test
    files:
      - tb/tb_spi_ctrl.sv

/* tb/tb_spi_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI controller testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_spi_ctrl
    import spi_pkg::*;
();

    localparam int MAX_LINES = 16;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 reg_wr_i;
    logic                 reg_rd_i;
    reg_addr_t            reg_addr_i;
    reg_data_t            reg_wdata_i;
    reg_data_t            reg_rdata_o;
    logic                 reg_rvalid_o;
    logic                 spi_sclk_o;
    logic                 spi_mosi_o;
    logic [SLAVE_NUM-1:0] spi_cs_n_o;
    logic                 spi_miso_i;

    logic [31:0] st_cpol[MAX_LINES];
    logic [31:0] st_cpha[MAX_LINES];
    logic [31:0] st_div[MAX_LINES];
    logic [31:0] st_sel[MAX_LINES];
    logic [31:0] st_cnt[MAX_LINES];
    logic [31:0] st_word[MAX_LINES][4];
    logic [31:0] st_status[MAX_LINES];
    int          num_lines = 0;

    int          mismatches = 0;
    int          other_errs = 0;
    int          limit = 0;
    logic        limit_set = 1'b0;
    int          cycles = 0;
    logic [31:0] rand_state = 32'h8177_d6d9;

    // Frame monitor state
    logic                 mon_on = 1'b0;
    logic                 frame_chk = 1'b1;
    logic                 in_frame = 1'b0;
    logic                 last_sclk = 1'b0;
    logic                 exp_cpol = 1'b0;
    logic [SLAVE_NUM-1:0] exp_cs = '1;
    int                   exp_div = 0;
    int                   edge_cnt = 0;
    int                   hp_len = 0;
    int                   frames_seen = 0;

    spi_ctrl_top uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .reg_wr_i    (reg_wr_i),
        .reg_rd_i    (reg_rd_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .reg_rvalid_o(reg_rvalid_o),
        .spi_sclk_o  (spi_sclk_o),
        .spi_mosi_o  (spi_mosi_o),
        .spi_cs_n_o  (spi_cs_n_o),
        .spi_miso_i  (spi_miso_i)
    );

    assign spi_miso_i = spi_mosi_o;  // Loopback

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [7:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[23:16];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input logic [31:0] data);
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge clk_i);
        reg_wr_i = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output logic [31:0] data);
        reg_rd_i   = 1'b1;
        reg_addr_i = addr;
        @(negedge clk_i);
        reg_rd_i = 1'b0;
        if (reg_rvalid_o !== 1'b1) begin
            $display("No read valid in the cycle after a read of address %0d", addr);
            other_errs++;
        end
        data = reg_rdata_o;
    endtask

    task automatic check_read(input reg_addr_t addr, input logic [31:0] exp, input string name);
        logic [31:0] data;
        reg_read(addr, data);
        check_value({"reg_rdata_o ", name}, exp, data);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = '1;
        while (st[STAT_BUSY_BIT]) reg_read(ADDR_STATUS, st);
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        logic [31:0] cp, ch, dv, sl, cn, w0, w1, w2, w3, es;
        fd = $fopen("tb/spi_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/spi_stim.txt");
            other_errs++;
        end else begin
            while (!$feof(fd) && num_lines < MAX_LINES) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                cp, ch, dv, sl, cn, w0, w1, w2, w3, es);
                    if (n == 10) begin
                        st_cpol[num_lines]    = cp;
                        st_cpha[num_lines]    = ch;
                        st_div[num_lines]     = dv;
                        st_sel[num_lines]     = sl;
                        st_cnt[num_lines]     = cn;
                        st_word[num_lines][0] = w0;
                        st_word[num_lines][1] = w1;
                        st_word[num_lines][2] = w2;
                        st_word[num_lines][3] = w3;
                        st_status[num_lines]  = es;
                        num_lines++;
                    end else begin
                        $display("Stimulus line could not be parsed: %s", line);
                        other_errs++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_line(input int i);
        spi_word_t exp_words[$];
        spi_word_t word;
        int        frames_start;
        reg_write(ADDR_CONTROL, {st_cpha[i][0], st_cpol[i][0]});
        exp_cpol = st_cpol[i][0];
        reg_write(ADDR_DIVIDER, st_div[i]);
        exp_div = st_div[i];
        reg_write(ADDR_SELECT, st_sel[i]);
        exp_cs = ~(SLAVE_NUM'(1) << st_sel[i][1:0]);
        check_read(ADDR_CONTROL, {st_cpha[i][0], st_cpol[i][0]}, "CONTROL");
        check_read(ADDR_DIVIDER, st_div[i] & 32'hffff, "DIVIDER");
        check_read(ADDR_SELECT, st_sel[i] & 32'h3, "SELECT");
        frames_start = frames_seen;
        for (int w = 0; w < st_cnt[i]; w++) begin
            word = (st_word[i][w] == 0) ? next_random() : spi_word_t'(st_word[i][w]);
            exp_words.push_back(word);
            reg_write(ADDR_TX, word);
        end
        wait_idle();
        foreach (exp_words[w]) check_read(ADDR_RX, exp_words[w], "RX word");
        check_read(ADDR_STATUS, st_status[i], "STATUS after transfer");
        check_value("spi_cs_n_o frame count", st_cnt[i], frames_seen - frames_start);
    endtask

    task automatic fifo_limits();
        frame_chk = 1'b0;  // The frame below is cut short by the soft reset
        reg_write(ADDR_DIVIDER, 32'h00ff);
        exp_div = 32'h00ff;
        for (int w = 0; w < FIFO_DEPTH + 2; w++) reg_write(ADDR_TX, next_random());
        check_read(ADDR_STATUS, 32'h19, "STATUS with TX full");
        check_read(ADDR_RX, 32'h0, "RX read when empty");
        reg_write(ADDR_CONTROL, {29'b0, 1'b1, 1'b0, exp_cpol});
        check_read(ADDR_STATUS, 32'h05, "STATUS after soft reset");
    endtask

    // Chip select, SCLK idle level, edge count and half-period per frame
    always @(posedge clk_i) begin
        if (mon_on) begin
            if (spi_cs_n_o == '1) begin
                check_value("spi_sclk_o idle", exp_cpol, spi_sclk_o);
                if (in_frame) begin
                    in_frame = 1'b0;
                    frames_seen++;
                    if (frame_chk) check_value("spi_sclk_o edge count", SPI_EDGE_NUM, edge_cnt);
                end
            end else begin
                check_value("spi_cs_n_o", exp_cs, spi_cs_n_o);
                if (!in_frame) begin
                    in_frame = 1'b1;
                    edge_cnt = 0;
                    hp_len   = 0;
                end else begin
                    hp_len++;
                    if (spi_sclk_o != last_sclk) begin
                        edge_cnt++;
                        if (edge_cnt > 1 && frame_chk) begin
                            check_value("spi_sclk_o half-period", exp_div + 1, hp_len);
                        end
                        hp_len = 0;
                    end
                end
            end
            last_sclk = spi_sclk_o;
        end
    end

    initial begin
        wait (limit_set);
        while (cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout after %0d cycles", cycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        rst_n_i     = 1'b0;
        reg_wr_i    = 1'b0;
        reg_rd_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        load_stim();
        limit = 2000;
        for (int i = 0; i < num_lines; i++) limit += st_cnt[i] * (st_div[i] + 1) * 18;
        limit_set = 1'b1;
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        mon_on = 1'b1;
        check_value("spi_cs_n_o after reset", {SLAVE_NUM{1'b1}}, spi_cs_n_o);
        check_value("spi_sclk_o after reset", 0, spi_sclk_o);
        check_value("reg_rvalid_o after reset", 0, reg_rvalid_o);
        check_read(ADDR_STATUS, 32'h05, "STATUS after reset");
        for (int i = 0; i < num_lines; i++) run_line(i);
        if (num_lines > 0) begin
            fifo_limits();
        end else begin
            $display("No transfers were read from the stimulus file");
            other_errs++;
        end
        $display("Checks done with %0d mismatches and %0d other errors", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* source/spi_ctrl_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI controller top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module spi_ctrl_top
    import spi_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 reg_wr_i,
    input  logic                 reg_rd_i,
    input  reg_addr_t            reg_addr_i,
    input  reg_data_t            reg_wdata_i,
    output reg_data_t            reg_rdata_o,
    output logic                 reg_rvalid_o,

    output logic                 spi_sclk_o,
    output logic                 spi_mosi_o,
    output logic [SLAVE_NUM-1:0] spi_cs_n_o,
    input  logic                 spi_miso_i
);

    logic       cpol;
    logic       cpha;
    logic       soft_rst;
    logic       busy;
    spi_div_t   divider;
    slave_sel_t select;

    spi_stream_if tx_push ();
    spi_stream_if tx_pop ();
    spi_stream_if rx_push ();
    spi_stream_if rx_pop ();

    spi_reg_decode u_reg_decode (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .reg_wr_i    (reg_wr_i),
        .reg_rd_i    (reg_rd_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .reg_rvalid_o(reg_rvalid_o),
        .tx_push     (tx_push),
        .rx_pop      (rx_pop),
        .tx_avail_i  (tx_pop.valid),
        .rx_room_i   (rx_push.ready),
        .busy_i      (busy),
        .cpol_o      (cpol),
        .cpha_o      (cpha),
        .soft_rst_o  (soft_rst),
        .divider_o   (divider),
        .select_o    (select)
    );

    spi_word_fifo u_tx_fifo (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .flush_i(soft_rst),
        .in     (tx_push),
        .out    (tx_pop)
    );

    spi_word_fifo u_rx_fifo (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .flush_i(soft_rst),
        .in     (rx_push),
        .out    (rx_pop)
    );

    spi_shift_engine u_shift_engine (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .flush_i   (soft_rst),
        .cpol_i    (cpol),
        .cpha_i    (cpha),
        .divider_i (divider),
        .select_i  (select),
        .tx_pop    (tx_pop),
        .rx_push   (rx_push),
        .busy_o    (busy),
        .spi_sclk_o(spi_sclk_o),
        .spi_mosi_o(spi_mosi_o),
        .spi_cs_n_o(spi_cs_n_o),
        .spi_miso_i(spi_miso_i)
    );

endmodule

/* source/spi_shift_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI master shift engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module spi_shift_engine
    import spi_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 flush_i,

    input  logic                 cpol_i,
    input  logic                 cpha_i,
    input  spi_div_t             divider_i,
    input  slave_sel_t           select_i,

    spi_stream_if.consumer       tx_pop,
    spi_stream_if.producer       rx_push,

    output logic                 busy_o,
    output logic                 spi_sclk_o,
    output logic                 spi_mosi_o,
    output logic [SLAVE_NUM-1:0] spi_cs_n_o,
    input  logic                 spi_miso_i
);

    spi_state_e state_q;
    spi_div_t   hp_cnt_q;
    edge_cnt_t  edge_cnt_q;
    logic       phase_q;     // SCLK relative to its idle level
    slave_sel_t sel_q;
    spi_word_t  tx_q;
    spi_word_t  rx_q;
    logic       hp_tick;
    logic       bit_edge;
    logic       sample_edge;
    logic       shift_edge;

    assign hp_tick  = hp_cnt_q == '0;
    assign bit_edge = (state_q == SHIFT) && hp_tick;

    // Even count is the leading edge of a bit
    assign sample_edge = bit_edge && (edge_cnt_q[0] == cpha_i);
    // With CPHA 1 the first edge only launches the MSB that is already out
    assign shift_edge  = bit_edge && (edge_cnt_q[0] != cpha_i) && (edge_cnt_q != '0);

    assign tx_pop.ready  = (state_q == IDLE) && !flush_i;
    assign rx_push.valid = state_q == DONE;
    assign rx_push.data  = rx_q;

    assign busy_o     = (state_q != IDLE) || tx_pop.valid;
    assign spi_sclk_o = cpol_i ^ phase_q;
    assign spi_mosi_o = tx_q[SPI_DATA_WIDTH-1];

    always_comb begin
        spi_cs_n_o = '1;
        if (state_q != IDLE) spi_cs_n_o[sel_q] = 1'b0;  // Low for the whole frame
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q    <= IDLE;
            hp_cnt_q   <= '0;
            edge_cnt_q <= '0;
            phase_q    <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (tx_pop.valid) begin
                        state_q    <= SETUP;
                        hp_cnt_q   <= divider_i;
                        edge_cnt_q <= '0;
                    end
                end
                SETUP: begin
                    if (hp_tick) begin
                        state_q  <= SHIFT;
                        hp_cnt_q <= divider_i;
                    end else begin
                        hp_cnt_q <= hp_cnt_q - 1'b1;
                    end
                end
                SHIFT: begin
                    if (hp_tick) begin
                        phase_q    <= ~phase_q;
                        edge_cnt_q <= edge_cnt_q + 1'b1;
                        hp_cnt_q   <= divider_i;
                        if (edge_cnt_q == edge_cnt_t'(SPI_EDGE_NUM - 1)) state_q <= HOLD;
                    end else begin
                        hp_cnt_q <= hp_cnt_q - 1'b1;
                    end
                end
                HOLD: begin
                    if (hp_tick) state_q <= DONE;
                    else hp_cnt_q <= hp_cnt_q - 1'b1;
                end
                DONE: begin
                    if (rx_push.ready) state_q <= IDLE;  // Wait here while RX is full
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_pop.valid && tx_pop.ready) begin
            tx_q  <= tx_pop.data;
            sel_q <= select_i;
        end else if (shift_edge) begin
            tx_q <= {tx_q[SPI_DATA_WIDTH-2:0], 1'b0};  // MSB first
        end
        if (sample_edge) rx_q <= {rx_q[SPI_DATA_WIDTH-2:0], spi_miso_i};
    end

    // Selected slave stays put until the frame is over
    a_cs_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q != IDLE) |=> (state_q == IDLE) || $stable(spi_cs_n_o));

    a_idle_sclk : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == IDLE) |-> (spi_sclk_o == cpol_i));

endmodule

/* source/spi_reg_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI register decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module spi_reg_decode
    import spi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       reg_wr_i,
    input  logic       reg_rd_i,
    input  reg_addr_t  reg_addr_i,
    input  reg_data_t  reg_wdata_i,
    output reg_data_t  reg_rdata_o,
    output logic       reg_rvalid_o,

    spi_stream_if.producer tx_push,
    spi_stream_if.consumer rx_pop,

    input  logic       tx_avail_i,  // TX FIFO holds a word for the engine
    input  logic       rx_room_i,   // RX FIFO can take a word
    input  logic       busy_i,

    output logic       cpol_o,
    output logic       cpha_o,
    output logic       soft_rst_o,
    output spi_div_t   divider_o,
    output slave_sel_t select_o
);

    logic       cpol_q;
    logic       cpha_q;
    spi_div_t   divider_q;
    slave_sel_t select_q;
    reg_data_t  rdata_d;
    reg_data_t  rdata_q;
    logic       rvalid_q;
    logic       wr_ctrl;

    assign wr_ctrl    = reg_wr_i && (reg_addr_i == ADDR_CONTROL);
    assign soft_rst_o = wr_ctrl && reg_wdata_i[CTRL_SOFT_RST_BIT];  // Flush on the write edge

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cpol_q    <= 1'b0;
            cpha_q    <= 1'b0;
            divider_q <= '0;
            select_q  <= '0;
            rvalid_q  <= 1'b0;
        end else begin
            rvalid_q <= reg_rd_i;
            if (wr_ctrl) begin
                cpol_q <= reg_wdata_i[CTRL_CPOL_BIT];
                cpha_q <= reg_wdata_i[CTRL_CPHA_BIT];
            end
            if (reg_wr_i && (reg_addr_i == ADDR_DIVIDER)) begin
                divider_q <= reg_wdata_i[SPI_DIVIDER_WIDTH-1:0];
            end
            if (reg_wr_i && (reg_addr_i == ADDR_SELECT)) begin
                select_q <= reg_wdata_i[$bits(slave_sel_t)-1:0];
            end
        end
    end

    assign tx_push.data  = reg_wdata_i[SPI_DATA_WIDTH-1:0];
    assign tx_push.valid = reg_wr_i && (reg_addr_i == ADDR_TX) && tx_push.ready;  // Drop when full
    assign rx_pop.ready  = reg_rd_i && (reg_addr_i == ADDR_RX);

    always_comb begin
        rdata_d = '0;
        case (reg_addr_i)
            ADDR_CONTROL: begin
                rdata_d[CTRL_CPOL_BIT] = cpol_q;
                rdata_d[CTRL_CPHA_BIT] = cpha_q;
            end
            ADDR_DIVIDER: rdata_d[SPI_DIVIDER_WIDTH-1:0] = divider_q;
            ADDR_SELECT:  rdata_d[$bits(slave_sel_t)-1:0] = select_q;
            ADDR_STATUS: begin
                rdata_d[STAT_RX_EMPTY_BIT] = !rx_pop.valid;
                rdata_d[STAT_RX_FULL_BIT]  = !rx_room_i;
                rdata_d[STAT_TX_EMPTY_BIT] = !tx_avail_i;
                rdata_d[STAT_TX_FULL_BIT]  = !tx_push.ready;
                rdata_d[STAT_BUSY_BIT]     = busy_i;
            end
            ADDR_RX: begin
                if (rx_pop.valid) rdata_d[SPI_DATA_WIDTH-1:0] = rx_pop.data;  // Empty reads zero
            end
            default: rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reg_rd_i) rdata_q <= rdata_d;
    end

    assign reg_rdata_o  = rdata_q;
    assign reg_rvalid_o = rvalid_q;
    assign cpol_o       = cpol_q;
    assign cpha_o       = cpha_q;
    assign divider_o    = divider_q;
    assign select_o     = select_q;

    a_no_wr_rd : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(reg_wr_i && reg_rd_i));

endmodule

/* source/spi_word_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI word FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module spi_word_fifo
    import spi_pkg::*;
(
    input logic clk_i,
    input logic rst_n_i,
    input logic flush_i,

    spi_stream_if.consumer in,
    spi_stream_if.producer out
);

    spi_word_t mem[FIFO_DEPTH];
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    fifo_cnt_t count_q;
    logic      do_push;
    logic      do_pop;

    assign in.ready  = count_q != fifo_cnt_t'(FIFO_DEPTH);
    assign out.valid = count_q != '0;
    assign out.data  = mem[rd_ptr_q];  // Fall-through head word

    assign do_push = in.valid && in.ready;
    assign do_pop  = out.valid && out.ready;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) mem[wr_ptr_q] <= in.data;
    end

    // A full FIFO without a pop keeps its count, so no word was written over
    a_no_push_full : assert property (@(posedge clk_i)
        (rst_n_i && !flush_i && count_q == fifo_cnt_t'(FIFO_DEPTH) && !do_pop)
            |=> (count_q == fifo_cnt_t'(FIFO_DEPTH)));

    a_count_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_q <= fifo_cnt_t'(FIFO_DEPTH));

endmodule

/* source/spi_stream_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI word stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

interface spi_stream_if
    import spi_pkg::*;
();

    spi_word_t data;
    logic      valid;
    logic      ready;  // Word moves when valid and ready are both high

    modport producer(output data, output valid, input ready);

    modport consumer(input data, input valid, output ready);

endinterface

/* source/spi_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI controller definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package spi_pkg;

    localparam int SPI_DATA_WIDTH     = 8;
    localparam int SPI_EDGE_NUM       = 2 * SPI_DATA_WIDTH;  // SCLK edges per word
    localparam int SPI_EDGE_CNT_WIDTH = $clog2(SPI_EDGE_NUM);
    localparam int SPI_DIVIDER_WIDTH  = 16;
    localparam int SLAVE_NUM          = 4;

    localparam int REG_ADDR_WIDTH = 3;
    localparam int REG_DATA_WIDTH = 32;

    localparam int FIFO_DEPTH     = 16;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    typedef logic [SPI_DATA_WIDTH-1:0]     spi_word_t;
    typedef logic [SPI_EDGE_CNT_WIDTH-1:0] edge_cnt_t;
    typedef logic [SPI_DIVIDER_WIDTH-1:0]  spi_div_t;   // Half-period is value + 1 cycles
    typedef logic [$clog2(SLAVE_NUM)-1:0]  slave_sel_t;
    typedef logic [REG_ADDR_WIDTH-1:0]     reg_addr_t;
    typedef logic [REG_DATA_WIDTH-1:0]     reg_data_t;
    typedef logic [FIFO_PTR_WIDTH-1:0]     fifo_ptr_t;
    typedef logic [FIFO_CNT_WIDTH-1:0]     fifo_cnt_t;

    // Register map
    localparam reg_addr_t ADDR_CONTROL = reg_addr_t'(0);
    localparam reg_addr_t ADDR_DIVIDER = reg_addr_t'(1);
    localparam reg_addr_t ADDR_SELECT  = reg_addr_t'(2);
    localparam reg_addr_t ADDR_STATUS  = reg_addr_t'(3);
    localparam reg_addr_t ADDR_TX      = reg_addr_t'(4);  // Write pushes a word
    localparam reg_addr_t ADDR_RX      = reg_addr_t'(5);  // Read pops a word

    localparam int CTRL_CPOL_BIT     = 0;
    localparam int CTRL_CPHA_BIT     = 1;
    localparam int CTRL_SOFT_RST_BIT = 2;

    localparam int STAT_RX_EMPTY_BIT = 0;
    localparam int STAT_RX_FULL_BIT  = 1;
    localparam int STAT_TX_EMPTY_BIT = 2;
    localparam int STAT_TX_FULL_BIT  = 3;
    localparam int STAT_BUSY_BIT     = 4;

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        SHIFT,
        HOLD,
        DONE
    } spi_state_e;

endpackage
